// File: rs_pkg.sv
// widths, packet structs and instruction decode shared by every block of the issue stage
package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////

	// dispatch, issue and cdb width
	localparam int N_WAY = 2;
	localparam int N_RS = 8;
	// tag 0 is no register, always ready
	localparam int TAG_BITS = 6;
	localparam int SQ_BITS = 4;
	// rank 1 is the oldest, 0 marks a free slot
	localparam int AGE_BITS = $clog2(N_RS) + 1;
	// issue limit runs 0..N_WAY
	localparam int LIM_BITS = $clog2(N_WAY + 1);

	// major opcode shared by loads and stores
	localparam logic [6:0] OP_MEM = 7'b0000011;

	//////////////////////////////////////////////////////////////////////
	// instruction word
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0]  opcode;
		logic [2:0]  funct;
		logic [21:0] unused;
	} alu_fmt_t;

	typedef struct packed {
		logic [6:0]  opcode;
		logic        store;
		logic [23:0] offset;
	} mem_fmt_t;

	// opcode sits in the same bits in both views
	typedef union packed {
		alu_fmt_t alu_fmt;
		mem_fmt_t mem_fmt;
	} inst_word_u;

	function automatic logic is_mem_op(input inst_word_u inst);
		return inst.mem_fmt.opcode == OP_MEM;
	endfunction

	function automatic logic is_store_op(input inst_word_u inst);
		return is_mem_op(inst) && inst.mem_fmt.store;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// packets
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                valid;
		inst_word_u          inst;
		logic [TAG_BITS-1:0] dest_tag;
		logic [TAG_BITS-1:0] src1_tag;
		logic [TAG_BITS-1:0] src2_tag;
		logic                src1_rdy;
		logic                src2_rdy;
		logic [SQ_BITS-1:0]  sq_idx;
	} dispatch_pkt_t;

	// one station slot
	typedef struct packed {
		logic                busy;
		logic                issued;
		inst_word_u          inst;
		logic [TAG_BITS-1:0] dest_tag;
		logic [TAG_BITS-1:0] src1_tag;
		logic [TAG_BITS-1:0] src2_tag;
		logic                src1_rdy;
		logic                src2_rdy;
		logic [SQ_BITS-1:0]  sq_idx;
		logic [AGE_BITS-1:0] age;
	} rs_entry_t;

	typedef struct packed {
		logic                valid;
		inst_word_u          inst;
		logic [TAG_BITS-1:0] dest_tag;
		logic [TAG_BITS-1:0] src1_tag;
		logic [TAG_BITS-1:0] src2_tag;
		logic [SQ_BITS-1:0]  sq_idx;
	} issue_pkt_t;

	// one lane of the common data bus
	typedef struct packed {
		logic                valid;
		logic [TAG_BITS-1:0] tag;
	} cdb_t;

endpackage

// File: reservation_station.sv
// eight-entry station: holds dispatched tags, wakes sources from the cdb and frees completions
`timescale 1ns/1ns

module reservation_station import rs_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	input  dispatch_pkt_t [N_WAY-1:0]    i_dispatch,
	input  cdb_t [N_WAY-1:0]             i_cdb,
	input  logic [N_RS-1:0]              i_issued_mask,
	input  logic                         i_flush,
	output rs_entry_t [N_RS-1:0]         o_entries,
	output logic [AGE_BITS-1:0]          o_free_count
);

	rs_entry_t [N_RS-1:0] entry_q;
	rs_entry_t [N_RS-1:0] entry_d;
	rs_entry_t [N_RS-1:0] woken;
	logic [N_RS-1:0]      done;
	logic [AGE_BITS-1:0]  live_cnt;
	logic [AGE_BITS-1:0]  next_age;
	logic [AGE_BITS-1:0]  shift;
	logic                 keep;
	logic                 placed;
	logic [LIM_BITS-1:0]  disp_cnt;
	logic                 dup_dest;

	// source is ready if already marked, tag 0, or on the bus right now
	function automatic logic tag_ready(
		input logic [TAG_BITS-1:0] tag,
		input logic                rdy,
		input cdb_t [N_WAY-1:0]    cdb
	);
		logic r;
		r = rdy || (tag == '0);
		for (int l = 0; l < N_WAY; l++) begin
			if (cdb[l].valid && cdb[l].tag == tag)
				r = 1'b1;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// wakeup and completion
	//////////////////////////////////////////////////////////////////////

	// same-cycle wakeup so a dependent can go with its producer's broadcast
	always_comb begin
		for (int i = 0; i < N_RS; i++) begin
			woken[i] = entry_q[i];
			// nothing is offered for issue while a flush is pending
			woken[i].busy = entry_q[i].busy && !i_flush;
			woken[i].src1_rdy = tag_ready(entry_q[i].src1_tag, entry_q[i].src1_rdy, i_cdb);
			woken[i].src2_rdy = tag_ready(entry_q[i].src2_tag, entry_q[i].src2_rdy, i_cdb);
		end
	end

	assign o_entries = woken;

	// dest tag on the bus, slot goes free at the edge
	always_comb begin
		for (int i = 0; i < N_RS; i++) begin
			done[i] = 1'b0;
			for (int l = 0; l < N_WAY; l++) begin
				if (entry_q[i].busy && i_cdb[l].valid && i_cdb[l].tag == entry_q[i].dest_tag)
					done[i] = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		entry_d = entry_q;
		live_cnt = '0;
		shift = '0;
		keep = 1'b0;

		// survivors move down past every freed older rank
		for (int i = 0; i < N_RS; i++) begin
			shift = '0;
			for (int j = 0; j < N_RS; j++) begin
				if (done[j] && entry_q[j].age < entry_q[i].age)
					shift = shift + 1'b1;
			end
			keep = entry_q[i].busy && !done[i];
			entry_d[i].busy = keep;
			entry_d[i].issued = keep && (entry_q[i].issued || i_issued_mask[i]);
			entry_d[i].src1_rdy = woken[i].src1_rdy;
			entry_d[i].src2_rdy = woken[i].src2_rdy;
			entry_d[i].age = keep ? entry_q[i].age - shift : '0;
			if (keep)
				live_cnt = live_cnt + 1'b1;
		end

		// new packets take the lowest free slots, ranked after the survivors
		next_age = live_cnt;
		placed = 1'b0;
		for (int l = 0; l < N_WAY; l++) begin
			placed = 1'b0;
			if (i_dispatch[l].valid) begin
				next_age = next_age + 1'b1;
				for (int j = 0; j < N_RS; j++) begin
					if (!placed && !entry_d[j].busy) begin
						entry_d[j].busy = 1'b1;
						entry_d[j].issued = 1'b0;
						entry_d[j].inst = i_dispatch[l].inst;
						entry_d[j].dest_tag = i_dispatch[l].dest_tag;
						entry_d[j].src1_tag = i_dispatch[l].src1_tag;
						entry_d[j].src2_tag = i_dispatch[l].src2_tag;
						entry_d[j].src1_rdy = tag_ready(i_dispatch[l].src1_tag,
							i_dispatch[l].src1_rdy, i_cdb);
						entry_d[j].src2_rdy = tag_ready(i_dispatch[l].src2_tag,
							i_dispatch[l].src2_rdy, i_cdb);
						entry_d[j].sq_idx = i_dispatch[l].sq_idx;
						entry_d[j].age = next_age;
						placed = 1'b1;
					end
				end
			end
		end

		// branch flush wipes everything, including this cycle's dispatch
		if (i_flush) begin
			for (int i = 0; i < N_RS; i++) begin
				entry_d[i].busy = 1'b0;
				entry_d[i].issued = 1'b0;
				entry_d[i].age = '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < N_RS; i++) begin
				entry_q[i].busy <= 1'b0;
				entry_q[i].issued <= 1'b0;
				entry_q[i].age <= '0;
			end
		end else begin
			entry_q <= entry_d;
		end
	end

	always_comb begin
		o_free_count = '0;
		for (int i = 0; i < N_RS; i++) begin
			if (!entry_q[i].busy)
				o_free_count = o_free_count + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// dispatcher contract
	//////////////////////////////////////////////////////////////////////

	// lane count and dest tags against what is already live
	always_comb begin
		disp_cnt = '0;
		dup_dest = 1'b0;
		for (int l = 0; l < N_WAY; l++) begin
			if (i_dispatch[l].valid) begin
				disp_cnt = disp_cnt + 1'b1;
				for (int i = 0; i < N_RS; i++) begin
					if (entry_q[i].busy && !done[i] &&
						entry_q[i].dest_tag == i_dispatch[l].dest_tag)
						dup_dest = 1'b1;
				end
				for (int k = 0; k < l; k++) begin
					if (i_dispatch[k].valid && i_dispatch[k].dest_tag == i_dispatch[l].dest_tag)
						dup_dest = 1'b1;
				end
			end
		end
	end

	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		disp_cnt <= o_free_count)
		else $error("dispatch of %0d lanes with %0d free slots", disp_cnt, o_free_count);

	a_unique_dest: assert property (@(posedge clock) disable iff (reset) !dup_dest)
		else $error("dispatched dest tag already live in the station");

endmodule

// File: issue_select.sv
// oldest-first select of ready station entries, up to the downstream limit, with store gating
`timescale 1ns/1ns

module issue_select import rs_pkg::*; (
	input  rs_entry_t [N_RS-1:0]   i_entries,
	input  logic [LIM_BITS-1:0]    i_issue_limit,
	input  logic [SQ_BITS-1:0]     i_store_ok_idx,
	output issue_pkt_t [N_WAY-1:0] o_issue,
	output logic [N_RS-1:0]        o_issued_mask
);

	logic [N_RS-1:0]     cand;
	logic [LIM_BITS-1:0] lane_cnt;

	// busy, not yet sent, both sources ready
	always_comb begin
		for (int i = 0; i < N_RS; i++) begin
			cand[i] = i_entries[i].busy && !i_entries[i].issued &&
				i_entries[i].src1_rdy && i_entries[i].src2_rdy;
			// store waits for the store queue
			if (is_store_op(i_entries[i].inst) && i_entries[i].sq_idx > i_store_ok_idx)
				cand[i] = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// rank walk, oldest first
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		o_issue = '0;
		o_issued_mask = '0;
		lane_cnt = '0;
		for (int r = 1; r <= N_RS; r++) begin
			for (int i = 0; i < N_RS; i++) begin
				if (cand[i] && i_entries[i].age == AGE_BITS'(r) &&
					lane_cnt < i_issue_limit && lane_cnt < N_WAY) begin
					o_issue[lane_cnt].valid = 1'b1;
					o_issue[lane_cnt].inst = i_entries[i].inst;
					o_issue[lane_cnt].dest_tag = i_entries[i].dest_tag;
					o_issue[lane_cnt].src1_tag = i_entries[i].src1_tag;
					o_issue[lane_cnt].src2_tag = i_entries[i].src2_tag;
					o_issue[lane_cnt].sq_idx = i_entries[i].sq_idx;
					o_issued_mask[i] = 1'b1;
					lane_cnt = lane_cnt + 1'b1;
				end
			end
		end
	end

	// downstream never grants more lanes than the issue width
	always_comb begin
		assert (i_issue_limit <= N_WAY)
			else $error("issue limit %0d above issue width %0d", i_issue_limit, N_WAY);
	end

endmodule

// File: exec_pipe.sv
// tag-only execution pipe: alu ops return on the cdb after one stage, memory ops after two
`timescale 1ns/1ns

module exec_pipe import rs_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  issue_pkt_t [N_WAY-1:0] i_issue,
	input  logic                   i_flush,
	output cdb_t [N_WAY-1:0]       o_cdb
);

	typedef struct packed {
		logic                valid;
		logic                mem;
		logic [TAG_BITS-1:0] tag;
	} stage_t;

	stage_t [N_WAY-1:0] s1_q;
	cdb_t [N_WAY-1:0]   s2_q;
	// up to two results per lane position before the merge
	logic [$clog2(2*N_WAY+1)-1:0] res_cnt;

	//////////////////////////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || i_flush) begin
			for (int l = 0; l < N_WAY; l++) begin
				s1_q[l].valid <= 1'b0;
				s2_q[l].valid <= 1'b0;
			end
		end else begin
			for (int l = 0; l < N_WAY; l++) begin
				s1_q[l].valid <= i_issue[l].valid;
				s1_q[l].mem <= is_mem_op(i_issue[l].inst);
				s1_q[l].tag <= i_issue[l].dest_tag;
				// only loads and stores go on to stage 2
				s2_q[l].valid <= s1_q[l].valid && s1_q[l].mem;
				s2_q[l].tag <= s1_q[l].tag;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// cdb merge
	//////////////////////////////////////////////////////////////////////

	// stage 2 first, then alu results from stage 1, packed low first
	always_comb begin
		o_cdb = '0;
		res_cnt = '0;
		for (int l = 0; l < N_WAY; l++) begin
			if (s2_q[l].valid) begin
				if (res_cnt < N_WAY) begin
					o_cdb[res_cnt].valid = 1'b1;
					o_cdb[res_cnt].tag = s2_q[l].tag;
				end
				res_cnt = res_cnt + 1'b1;
			end
		end
		for (int l = 0; l < N_WAY; l++) begin
			if (s1_q[l].valid && !s1_q[l].mem) begin
				if (res_cnt < N_WAY) begin
					o_cdb[res_cnt].valid = 1'b1;
					o_cdb[res_cnt].tag = s1_q[l].tag;
				end
				res_cnt = res_cnt + 1'b1;
			end
		end
		// in-flight work is dead during a flush
		if (i_flush) begin
			for (int l = 0; l < N_WAY; l++)
				o_cdb[l].valid = 1'b0;
		end
	end

	// mem issue at c followed by alu issue at c+1 must not exceed the bus
	a_cdb_room: assert property (@(posedge clock) disable iff (reset || i_flush)
		res_cnt <= N_WAY)
		else $error("%0d completions for a %0d-wide cdb", res_cnt, N_WAY);

endmodule

// File: issue_core_top.sv
// issue stage top: station, oldest-first select and execution pipe with the cdb fed back
`timescale 1ns/1ns

module issue_core_top import rs_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  dispatch_pkt_t [N_WAY-1:0] i_dispatch,
	input  logic [LIM_BITS-1:0]       i_issue_limit,
	input  logic [SQ_BITS-1:0]        i_store_ok_idx,
	input  logic                      i_flush,
	output issue_pkt_t [N_WAY-1:0]    o_issue,
	output cdb_t [N_WAY-1:0]          o_cdb,
	output logic [AGE_BITS-1:0]       o_free_count
);

	// station view with wakeup applied
	rs_entry_t [N_RS-1:0] entries;
	logic [N_RS-1:0]      issued_mask;

	reservation_station u_rs (
		.clock        (clock),
		.reset        (reset),
		.i_dispatch   (i_dispatch),
		.i_cdb        (o_cdb),
		.i_issued_mask(issued_mask),
		.i_flush      (i_flush),
		.o_entries    (entries),
		.o_free_count (o_free_count)
	);

	issue_select u_sel (
		.i_entries     (entries),
		.i_issue_limit (i_issue_limit),
		.i_store_ok_idx(i_store_ok_idx),
		.o_issue       (o_issue),
		.o_issued_mask (issued_mask)
	);

	exec_pipe u_exec (
		.clock  (clock),
		.reset  (reset),
		.i_issue(o_issue),
		.i_flush(i_flush),
		.o_cdb  (o_cdb)
	);

endmodule

// File: rs_tb_checks.svh
// compare tasks and scoreboard helpers for the issue-stage testbench, included inside rs_tb
`ifndef RS_TB_CHECKS_SVH
`define RS_TB_CHECKS_SVH

task automatic check_issue(input int step, input int lane, input issue_pkt_t got,
	input issue_pkt_t exp);
	// an idle lane carries no meaning beyond its valid bit
	if ((!got.valid && !exp.valid) || got == exp) begin
		n_pass++;
		$display("step %0d o_issue[%0d] ok", step, lane);
	end else begin
		n_fail++;
		$display("mismatch step %0d o_issue[%0d]: got %h expected %h", step, lane, got, exp);
	end
endtask

task automatic check_cdb(input int step, input int lane, input cdb_t got, input cdb_t exp);
	if ((!got.valid && !exp.valid) || got == exp) begin
		n_pass++;
		$display("step %0d o_cdb[%0d] ok", step, lane);
	end else begin
		n_fail++;
		$display("mismatch step %0d o_cdb[%0d]: got %h expected %h", step, lane, got, exp);
	end
endtask

task automatic check_free(input int step, input logic [AGE_BITS-1:0] got,
	input logic [AGE_BITS-1:0] exp);
	if (got == exp) begin
		n_pass++;
		$display("step %0d o_free_count ok", step);
	end else begin
		n_fail++;
		$display("mismatch step %0d o_free_count: got %h expected %h", step, got, exp);
	end
endtask

// tag broadcast this cycle by the model
function automatic logic on_cdb(input logic [TAG_BITS-1:0] tag);
	logic hit;
	hit = 1'b0;
	for (int l = 0; l < N_WAY; l++)
		if (exp_cdb[l].valid && exp_cdb[l].tag == tag)
			hit = 1'b1;
	return hit;
endfunction

function automatic logic src_ready(input logic [TAG_BITS-1:0] tag, input logic rdy);
	return rdy || tag == '0 || on_cdb(tag);
endfunction

// state change at the edge that ends the step
task automatic model_clock_edge(input int step, input step_t st);
	model_entry_t e;
	for (int k = mq.size() - 1; k >= 0; k--)
		if (on_cdb(mq[k].pkt.dest_tag))
			mq.delete(k);
	foreach (mq[k]) begin
		mq[k].pkt.src1_rdy = src_ready(mq[k].pkt.src1_tag, mq[k].pkt.src1_rdy);
		mq[k].pkt.src2_rdy = src_ready(mq[k].pkt.src2_tag, mq[k].pkt.src2_rdy);
	end
	// new work joins behind everything live, lane 0 first
	for (int l = 0; l < N_WAY; l++) begin
		if (st.disp[l].valid) begin
			e.pkt = st.disp[l];
			e.pkt.src1_rdy = src_ready(e.pkt.src1_tag, e.pkt.src1_rdy);
			e.pkt.src2_rdy = src_ready(e.pkt.src2_tag, e.pkt.src2_rdy);
			e.issued = 1'b0;
			mq.push_back(e);
		end
	end
	for (int k = fq.size() - 1; k >= 0; k--)
		if (fq[k].due <= step)
			fq.delete(k);
	if (st.flush) begin
		mq.delete();
		fq.delete();
	end
endtask

`endif

// File: rs_tb.sv
// testbench for issue_core_top: runs a step table against a tag-level scoreboard model
`timescale 1ns/1ns

module rs_tb import rs_pkg::*; ();

	localparam int PERIOD = 100;
	localparam logic [31:0] INST_ALU = {7'b0110011, 3'b000, 22'h0};
	localparam logic [31:0] INST_LD = {7'b0000011, 1'b0, 24'h10};
	localparam logic [31:0] INST_ST = {7'b0000011, 1'b1, 24'h20};
	// check code bits
	localparam logic [2:0] CHK_ALL = 3'b111;

	typedef struct packed {
		dispatch_pkt_t [N_WAY-1:0] disp;
		logic [LIM_BITS-1:0]       limit;
		logic [SQ_BITS-1:0]        ok_idx;
		logic                      flush;
		logic [2:0]                chk;
	} step_t;

	typedef struct packed {
		dispatch_pkt_t pkt;
		logic          issued;
	} model_entry_t;

	// result waiting to reach the cdb in step due
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic                mem;
		int                  due;
	} flight_t;

	logic                      clock;
	logic                      reset;
	dispatch_pkt_t [N_WAY-1:0] i_dispatch;
	logic [LIM_BITS-1:0]       i_issue_limit;
	logic [SQ_BITS-1:0]        i_store_ok_idx;
	logic                      i_flush;
	issue_pkt_t [N_WAY-1:0]    o_issue;
	cdb_t [N_WAY-1:0]          o_cdb;
	logic [AGE_BITS-1:0]       o_free_count;

	step_t                  steps[$];
	model_entry_t           mq[$];
	flight_t                fq[$];
	issue_pkt_t [N_WAY-1:0] exp_issue;
	cdb_t [N_WAY-1:0]       exp_cdb;
	int                     n_pass;
	int                     n_fail;
	int                     cycles;
	int                     timeout_cycles;

	`include "rs_tb_checks.svh"

	issue_core_top uut (
		.clock         (clock),
		.reset         (reset),
		.i_dispatch    (i_dispatch),
		.i_issue_limit (i_issue_limit),
		.i_store_ok_idx(i_store_ok_idx),
		.i_flush       (i_flush),
		.o_issue       (o_issue),
		.o_cdb         (o_cdb),
		.o_free_count  (o_free_count)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	function automatic dispatch_pkt_t make_pkt(input logic [31:0] inst, input int dest,
		input int src1, input int src2, input int sq);
		dispatch_pkt_t p;
		p = '0;
		p.valid = 1'b1;
		p.inst = inst;
		p.dest_tag = TAG_BITS'(dest);
		p.src1_tag = TAG_BITS'(src1);
		p.src2_tag = TAG_BITS'(src2);
		p.sq_idx = SQ_BITS'(sq);
		return p;
	endfunction

	// random source tags, marked ready so nothing waits on them
	function automatic dispatch_pkt_t make_filler(input int dest);
		dispatch_pkt_t p;
		p = make_pkt(INST_ALU, dest, $urandom % 64, $urandom % 64, 0);
		p.src1_rdy = 1'b1;
		p.src2_rdy = 1'b1;
		return p;
	endfunction

	task automatic add_step(input dispatch_pkt_t d0, input dispatch_pkt_t d1, input int limit,
		input int ok_idx, input logic flush, input logic [2:0] chk);
		step_t s;
		s.disp[0] = d0;
		s.disp[1] = d1;
		s.limit = LIM_BITS'(limit);
		s.ok_idx = SQ_BITS'(ok_idx);
		s.flush = flush;
		s.chk = chk;
		steps.push_back(s);
	endtask

	task automatic add_idle(input int n, input int limit, input int ok_idx);
		for (int i = 0; i < n; i++)
			add_step('0, '0, limit, ok_idx, 1'b0, CHK_ALL);
	endtask

	//////////////////////////////////////////////////////////////////////
	// step table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// two independent ops, then their completion
		add_step(make_pkt(INST_ALU, 1, 0, 0, 0), make_pkt(INST_ALU, 2, 0, 0, 0), 2, 0, 0, CHK_ALL);
		add_idle(3, 2, 0);
		// consumer of a load wakes on the load's broadcast
		add_step(make_pkt(INST_LD, 3, 0, 0, 0), make_pkt(INST_ALU, 4, 3, 0, 0), 2, 15, 0, CHK_ALL);
		add_idle(5, 2, 15);
		// held by back-pressure, then one per cycle in dispatch order
		add_step(make_pkt(INST_ALU, 5, 0, 0, 0), make_pkt(INST_ALU, 6, 0, 0, 0), 0, 15, 0, CHK_ALL);
		add_step(make_pkt(INST_ALU, 7, 0, 0, 0), '0, 0, 15, 0, CHK_ALL);
		add_idle(1, 0, 15);
		add_idle(1, 1, 15);
		// later op lands in the slot the oldest just freed but still ranks last
		add_step(make_pkt(INST_ALU, 14, 0, 0, 0), '0, 1, 15, 0, CHK_ALL);
		add_idle(4, 1, 15);
		// store outside the store queue window, younger alu op goes first
		add_step(make_pkt(INST_ST, 8, 0, 0, 5), make_pkt(INST_ALU, 9, 0, 0, 0), 2, 3, 0, CHK_ALL);
		add_idle(2, 2, 3);
		add_idle(4, 2, 5);
		for (int i = 0; i < 6; i++)
			add_step(make_filler(40 + 2 * i), make_filler(41 + 2 * i), 2, 15, 0, CHK_ALL);
		add_idle(3, 2, 15);
		// flush with a load and an alu op in flight and a consumer waiting
		add_step(make_pkt(INST_LD, 10, 0, 0, 0), make_pkt(INST_ALU, 12, 0, 0, 0), 2, 15, 0,
			CHK_ALL);
		add_step(make_pkt(INST_ALU, 11, 10, 0, 0), '0, 2, 15, 0, CHK_ALL);
		add_step('0, '0, 2, 15, 1'b1, CHK_ALL);
		add_idle(2, 2, 15);
		add_step(make_pkt(INST_ALU, 13, 0, 0, 0), '0, 2, 15, 0, CHK_ALL);
		add_idle(3, 2, 15);
	endtask

	// bus and issue lanes seen during the step; records what leaves
	task automatic model_cycle_outputs(input int step, input step_t st);
		int          n;
		logic [31:0] w;
		logic        held;
		flight_t     f;
		n = 0;
		exp_cdb = '0;
		exp_issue = '0;
		// memory results from stage 2 take the low lanes
		for (int pass = 0; pass < 2; pass++) begin
			foreach (fq[k]) begin
				if (fq[k].due == step && fq[k].mem == (pass == 0) && n < N_WAY && !st.flush) begin
					exp_cdb[n].valid = 1'b1;
					exp_cdb[n].tag = fq[k].tag;
					n++;
				end
			end
		end
		n = 0;
		foreach (mq[k]) begin
			w = mq[k].pkt.inst;
			held = w[31:25] == 7'b0000011 && w[24] && mq[k].pkt.sq_idx > st.ok_idx;
			if (!mq[k].issued && !held && !st.flush && n < st.limit &&
				src_ready(mq[k].pkt.src1_tag, mq[k].pkt.src1_rdy) &&
				src_ready(mq[k].pkt.src2_tag, mq[k].pkt.src2_rdy)) begin
				exp_issue[n].valid = 1'b1;
				exp_issue[n].inst = mq[k].pkt.inst;
				exp_issue[n].dest_tag = mq[k].pkt.dest_tag;
				exp_issue[n].src1_tag = mq[k].pkt.src1_tag;
				exp_issue[n].src2_tag = mq[k].pkt.src2_tag;
				exp_issue[n].sq_idx = mq[k].pkt.sq_idx;
				mq[k].issued = 1'b1;
				f.tag = mq[k].pkt.dest_tag;
				f.mem = w[31:25] == 7'b0000011;
				f.due = f.mem ? step + 2 : step + 1;
				fq.push_back(f);
				n++;
			end
		end
	endtask

	initial begin : watchdog
		cycles = 0;
		wait (timeout_cycles > 0);
		while (cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: step table still running after %0d cycles", cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		step_t st;
		void'($urandom(32));
		n_pass = 0;
		n_fail = 0;
		reset = 1'b1;
		i_dispatch = '0;
		i_issue_limit = '0;
		i_store_ok_idx = '0;
		i_flush = 1'b0;
		build_table();
		timeout_cycles = steps.size() * 4 + 20;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		foreach (steps[s]) begin
			st = steps[s];
			@(posedge clock);
			i_dispatch <= st.disp;
			i_issue_limit <= st.limit;
			i_store_ok_idx <= st.ok_idx;
			i_flush <= st.flush;
			// outputs settle by mid cycle
			@(negedge clock);
			if (st.chk[2])
				check_free(s, o_free_count, AGE_BITS'(N_RS - mq.size()));
			model_cycle_outputs(s, st);
			for (int l = 0; l < N_WAY; l++) begin
				if (st.chk[0])
					check_issue(s, l, o_issue[l], exp_issue[l]);
				if (st.chk[1])
					check_cdb(s, l, o_cdb[l], exp_cdb[l]);
			end
			model_clock_edge(s, st);
		end
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
rs_pkg.sv
reservation_station.sv
issue_select.sv
exec_pipe.sv
issue_core_top.sv
rs_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rs_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Test completed successfully

SRCS = $(filter-out +incdir+%,$(shell cat $(FILELIST))) rs_tb_checks.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
